//--- sim.f
+incdir+tb
source/hdmi_packet_pkg.sv
source/infoframe_builder.sv
source/audio_sample_buffer.sv
source/acr_timer.sv
source/packet_picker.sv
source/bch_ecc_stage.sv
source/data_island_scheduler.sv
tb/tb_data_island_scheduler.sv

//--- tb/tb_checks.svh
/* Stimulus tasks, reference BCH and InfoFrame model and compare tasks,
   included inside the data island scheduler testbench module */

`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// Serial BCH, one data bit per step, feedback taken from state bit 0
function automatic logic [7:0] bch_ref(input logic [55:0] data, input int nbits);
    logic [7:0] state;
    logic [7:0] next_state;
    logic feedback;
    state = 8'h00;
    for (int i = 0; i < nbits; i++)
    begin
        feedback = state[0] ^ data[i];
        for (int j = 0; j < 8; j++)
            next_state[j] = ((j < 7) ? state[j + 1] : 1'b0) ^ (feedback & BCH_POLY[j]);
        state = next_state;
    end
    return state;
endfunction

// PB0 makes header and payload bytes sum to zero, PB(7k) lands in SB0 of subpacket k
function automatic void build_infoframe(input header_t hdr, input logic [27:0][7:0] pb,
                                        output subpacket_t [3:0] body);
    logic [7:0] total;
    total = hdr[7:0] + hdr[15:8] + hdr[23:16];
    for (int i = 1; i < 28; i++)
        total = total + pb[i];
    pb[0] = 8'h00 - total;
    for (int k = 0; k < 4; k++)
        for (int b = 0; b < 7; b++)
            body[k].raw[8*b +: 8] = pb[7*k + b];
endfunction

task automatic header_compare(input string name, input header_t expected, input header_t actual);
    check_count++;
    if (actual !== expected)
    begin
        error_count++;
        $display("** Error %s: header expected %h, actual %h", name, expected, actual);
    end
endtask

task automatic subpacket_compare(input string name, input subpacket_t expected,
                                 input subpacket_t actual);
    check_count++;
    if (actual.raw !== expected.raw)
    begin
        error_count++;
        $display("** Error %s: subpacket expected %h, actual %h", name, expected.raw, actual.raw);
    end
endtask

task automatic parity_compare(input string name, input logic [7:0] expected,
                              input logic [7:0] actual);
    check_count++;
    if (actual !== expected)
    begin
        error_count++;
        $display("** Error %s: parity expected %h, actual %h", name, expected, actual);
    end
endtask

task automatic count_compare(input string name, input int expected, input int actual);
    check_count++;
    if (actual != expected)
    begin
        error_count++;
        $display("** Error %s: value expected %0d, actual %0d", name, expected, actual);
    end
endtask

task automatic note_problem(input string name, input string what);
    check_count++;
    error_count++;
    $display("%s: %s", name, what);
endtask

task automatic send_slot();
    int waited;
    waited = 0;
    @(negedge clk_pixel);
    slot_valid = 1'b1;
    @(posedge clk_pixel);
    while (!slot_ready && waited < WAIT_LIMIT)
    begin
        waited++;
        @(posedge clk_pixel);
    end
    if (!slot_ready)
        abort_run("slot request was never accepted");
    @(negedge clk_pixel);
    slot_valid = 1'b0;
endtask

// Leaves sample_valid high so samples can follow back to back
task automatic push_sample(input logic [AUDIO_BITS-1:0] left,
                           input logic [AUDIO_BITS-1:0] right);
    int waited;
    waited = 0;
    @(negedge clk_pixel);
    sample_valid = 1'b1;
    sample_left = left;
    sample_right = right;
    @(posedge clk_pixel);
    while (!sample_ready && waited < WAIT_LIMIT)
    begin
        waited++;
        @(posedge clk_pixel);
    end
    if (!sample_ready)
        abort_run("audio sample was never accepted");
    sent_left.push_back(left);
    sent_right.push_back(right);
endtask

task automatic push_random(input int count);
    for (int i = 0; i < count; i++)
        push_sample(AUDIO_BITS'($urandom), AUDIO_BITS'($urandom));
    @(negedge clk_pixel);
    sample_valid = 1'b0;
endtask

task automatic take_packet(output logic [31:0] hdr, output logic [3:0][63:0] sub,
                           output int latency);
    int waited;
    waited = 0;
    @(negedge clk_pixel);
    while (rx_header.size() == 0 && waited < WAIT_LIMIT)
    begin
        waited++;
        @(negedge clk_pixel);
    end
    if (rx_header.size() == 0)
        abort_run("no packet came out of the parity stage");
    hdr = rx_header.pop_front();
    sub = rx_sub.pop_front();
    latency = rx_cycle.pop_front() - accept_cycle.pop_front();
endtask

// A negative latency skips the latency check
task automatic expect_packet(input string name, input header_t hdr_exp,
                             input subpacket_t [3:0] sub_exp, input int latency_exp,
                             input bit sum_zero);
    logic [31:0] hdr;
    logic [3:0][63:0] sub;
    int latency;
    logic [7:0] total;
    take_packet(hdr, sub, latency);
    header_compare(name, hdr_exp, hdr[23:0]);
    parity_compare(name, bch_ref({32'h0, hdr[23:0]}, 24), hdr[31:24]);
    for (int k = 0; k < 4; k++)
    begin
        subpacket_compare(name, sub_exp[k], sub[k][55:0]);
        parity_compare(name, bch_ref(sub[k][55:0], 56), sub[k][63:56]);
    end
    if (latency_exp >= 0)
        count_compare(name, latency_exp, latency);
    if (sum_zero)
    begin
        total = hdr[7:0] + hdr[15:8] + hdr[23:16];
        for (int k = 0; k < 4; k++)
            for (int b = 0; b < 7; b++)
                total = total + sub[k][8*b +: 8];
        count_compare(name, 0, total);
    end
endtask

task automatic expect_audio(input string name, input int latency_exp);
    header_t hdr_exp;
    subpacket_t [3:0] sub_exp;
    hdr_exp = {8'h00, 8'h0F, PKT_AUDIO};
    sub_exp = '0;
    for (int k = 0; k < SAMPLES_PER_PACKET; k++)
    begin
        // B flag for the first frame of each IEC block
        if ((frame_index + k) % IEC_FRAME_COUNT == 0)
            hdr_exp[20 + k] = 1'b1;
        sub_exp[k].audio.left = sent_left.pop_front();
        sub_exp[k].audio.right = sent_right.pop_front();
        sub_exp[k].audio.parity_left = ($countones(sub_exp[k].audio.left) % 2) == 1;
        sub_exp[k].audio.parity_right = ($countones(sub_exp[k].audio.right) % 2) == 1;
    end
    frame_index = (frame_index + SAMPLES_PER_PACKET) % IEC_FRAME_COUNT;
    expect_packet(name, hdr_exp, sub_exp, latency_exp, 1'b0);
endtask

task automatic expect_idle(input string name);
    repeat (4) @(negedge clk_pixel);
    if (rx_header.size() != 0)
        note_problem(name, "a packet came out that no slot asked for");
endtask

`endif

//--- tb/tb_data_island_scheduler.sv
/* Directed testbench for the data island scheduler: drives slots, audio and
   back-pressure and checks every packet against a reference model */

`timescale 1ns/1ps

module tb_data_island_scheduler
    import hdmi_packet_pkg::*;
();

    localparam int WAIT_LIMIT = 100;

    logic clk_pixel;
    logic reset;
    logic video_field_end;
    logic slot_valid;
    logic slot_ready;
    logic sample_valid;
    logic sample_ready;
    logic [AUDIO_BITS-1:0] sample_left;
    logic [AUDIO_BITS-1:0] sample_right;
    logic out_valid;
    logic out_ready;
    logic [31:0] out_header;
    logic [63:0] out_sub0;
    logic [63:0] out_sub1;
    logic [63:0] out_sub2;
    logic [63:0] out_sub3;

    int cycle_count = 0;
    int error_count = 0;
    int check_count = 0;
    int test_count = 0;
    int failed_tests = 0;
    int frame_index = 0;
    int mark;
    int seed_draw;
    int accept_cycle [$];
    int rx_cycle [$];
    logic [31:0] rx_header [$];
    logic [3:0][63:0] rx_sub [$];
    logic [AUDIO_BITS-1:0] sent_left [$];
    logic [AUDIO_BITS-1:0] sent_right [$];

    data_island_scheduler i_data_island_scheduler (
        .clk_pixel       (clk_pixel),
        .reset           (reset),
        .video_field_end (video_field_end),
        .slot_valid      (slot_valid),
        .slot_ready      (slot_ready),
        .sample_valid    (sample_valid),
        .sample_ready    (sample_ready),
        .sample_left     (sample_left),
        .sample_right    (sample_right),
        .out_valid       (out_valid),
        .out_ready       (out_ready),
        .out_header      (out_header),
        .out_sub0        (out_sub0),
        .out_sub1        (out_sub1),
        .out_sub2        (out_sub2),
        .out_sub3        (out_sub3)
    );

    initial
    begin
        clk_pixel = 1'b0;
        forever
            #50 clk_pixel = ~clk_pixel;
    end

    // Slot accepts and output transfers stamped with the edge count
    always @(posedge clk_pixel)
    begin
        if (!reset && slot_valid && slot_ready)
            accept_cycle.push_back(cycle_count);
        if (!reset && out_valid && out_ready)
        begin
            rx_header.push_back(out_header);
            rx_sub.push_back({out_sub3, out_sub2, out_sub1, out_sub0});
            rx_cycle.push_back(cycle_count);
        end
        cycle_count = cycle_count + 1;
    end

    task automatic abort_run(input string reason);
        $display("Run stopped: %s", reason);
        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 test_count, failed_tests, check_count, error_count);
        $display("TEST FAIL");
        $finish;
    endtask

    task automatic finish_test(input string name, input int errors_before);
        test_count++;
        if (error_count != errors_before)
            failed_tests++;
        $display("%s: %0d errors", name, error_count - errors_before);
    endtask

    `include "tb_checks.svh"

    task automatic infoframe_sequence();
        header_t hdr_exp;
        logic [27:0][7:0] pb;
        subpacket_t [3:0] sub_exp;
        // Second pass relies on the field end clearing the sent flags
        repeat (2)
        begin
            @(negedge clk_pixel);
            video_field_end = 1'b1;
            @(negedge clk_pixel);
            video_field_end = 1'b0;
            // Two channels with SF field 3 for 48 kHz
            hdr_exp = {8'd10, 8'd1, PKT_AUDIO_IF};
            pb = '0;
            pb[1] = 8'h01;
            pb[2] = 8'h0C;
            build_infoframe(hdr_exp, pb, sub_exp);
            send_slot();
            expect_packet("infoframe_sequence", hdr_exp, sub_exp, 2, 1'b1);
            // RGB with a 4:3 picture and matching active format
            hdr_exp = {8'd13, 8'd2, PKT_AVI};
            pb = '0;
            pb[2] = 8'h18;
            pb[4] = {1'b0, VIDEO_ID_CODE};
            build_infoframe(hdr_exp, pb, sub_exp);
            send_slot();
            expect_packet("infoframe_sequence", hdr_exp, sub_exp, 2, 1'b1);
            hdr_exp = {8'd25, 8'd1, PKT_SPD};
            pb = '0;
            for (int i = 0; i < 8; i++)
                pb[1 + i] = VENDOR_NAME[8*(7 - i) +: 8];
            for (int i = 0; i < 16; i++)
                pb[9 + i] = PRODUCT_DESCRIPTION[8*(15 - i) +: 8];
            build_infoframe(hdr_exp, pb, sub_exp);
            send_slot();
            expect_packet("infoframe_sequence", hdr_exp, sub_exp, 2, 1'b1);
            send_slot();
            expect_packet("infoframe_sequence", '0, '0, 2, 1'b0);
        end
    endtask

    task automatic audio_fields();
        push_random(4);
        send_slot();
        expect_audio("audio_fields", 2);
        push_random(4);
        send_slot();
        expect_audio("audio_fields", 2);
    endtask

    task automatic output_stall();
        logic [31:0] held_header;
        logic [3:0][63:0] held_sub;
        push_random(8);
        @(negedge clk_pixel);
        out_ready = 1'b0;
        send_slot();
        send_slot();
        fork
            send_slot();
            begin
                @(negedge clk_pixel);
                held_header = out_header;
                held_sub = {out_sub3, out_sub2, out_sub1, out_sub0};
                repeat (8)
                begin
                    if (!out_valid)
                        note_problem("output_stall", "out_valid fell while out_ready was low");
                    if (slot_ready)
                        note_problem("output_stall", "slot_ready stayed high under back-pressure");
                    if (out_header !== held_header ||
                        {out_sub3, out_sub2, out_sub1, out_sub0} !== held_sub)
                        note_problem("output_stall", "outputs changed while held");
                    @(negedge clk_pixel);
                end
                out_ready = 1'b1;
            end
        join
        expect_audio("output_stall", -1);
        expect_audio("output_stall", -1);
        expect_packet("output_stall", '0, '0, -1, 1'b0);
        expect_idle("output_stall");
    endtask

    task automatic input_stall();
        push_random(8);
        if (sample_ready)
            note_problem("input_stall", "sample_ready stayed high with both halves full");
        fork
            push_sample(AUDIO_BITS'($urandom), AUDIO_BITS'($urandom));
            send_slot();
        join
        push_random(3);
        expect_audio("input_stall", 2);
        send_slot();
        expect_audio("input_stall", 2);
        send_slot();
        expect_audio("input_stall", 2);
        expect_idle("input_stall");
    endtask

    task automatic acr_first();
        header_t hdr_exp;
        subpacket_t [3:0] sub_exp;
        int waited;
        push_random(4);
        waited = 0;
        while (cycle_count < ACR_PERIOD + 16 && waited < 2 * ACR_PERIOD)
        begin
            waited++;
            @(negedge clk_pixel);
        end
        if (cycle_count < ACR_PERIOD + 16)
            abort_run("ACR period never elapsed");
        hdr_exp = {16'h0000, PKT_ACR};
        for (int k = 0; k < 4; k++)
        begin
            sub_exp[k].raw = '0;
            sub_exp[k].raw[15:8] = {4'h0, ACR_CTS[19:16]};
            sub_exp[k].raw[23:16] = ACR_CTS[15:8];
            sub_exp[k].raw[31:24] = ACR_CTS[7:0];
            sub_exp[k].raw[39:32] = {4'h0, ACR_N[19:16]};
            sub_exp[k].raw[47:40] = ACR_N[15:8];
            sub_exp[k].raw[55:48] = ACR_N[7:0];
        end
        send_slot();
        expect_packet("acr_first", hdr_exp, sub_exp, 2, 1'b0);
        send_slot();
        expect_audio("acr_first", 2);
    endtask

    initial
    begin
        seed_draw = $urandom(32'h69c6);
        reset = 1'b1;
        video_field_end = 1'b0;
        slot_valid = 1'b0;
        sample_valid = 1'b0;
        sample_left = '0;
        sample_right = '0;
        out_ready = 1'b1;
        repeat (5) @(posedge clk_pixel);
        @(negedge clk_pixel);
        reset = 1'b0;

        mark = error_count;
        infoframe_sequence();
        finish_test("infoframe_sequence", mark);
        mark = error_count;
        audio_fields();
        finish_test("audio_fields", mark);
        mark = error_count;
        output_stall();
        finish_test("output_stall", mark);
        mark = error_count;
        input_stall();
        finish_test("input_stall", mark);
        // Runs last since it waits out the ACR period
        mark = error_count;
        acr_first();
        finish_test("acr_first", mark);

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 test_count, failed_tests, check_count, error_count);
        if (error_count == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

//--- source/data_island_scheduler.sv
/* Top of the data island packet path: audio buffer and ACR timer feed the
   picker, whose packets pass through the BCH parity stage */

`timescale 1ns/1ps

module data_island_scheduler import hdmi_packet_pkg::*;
(
    input  logic clk_pixel,
    input  logic reset,
    input  logic video_field_end,
    input  logic slot_valid,
    output logic slot_ready,
    input  logic sample_valid,
    output logic sample_ready,
    input  logic [AUDIO_BITS-1:0] sample_left,
    input  logic [AUDIO_BITS-1:0] sample_right,
    output logic out_valid,
    input  logic out_ready,
    output logic [31:0] out_header,
    output logic [63:0] out_sub0,
    output logic [63:0] out_sub1,
    output logic [63:0] out_sub2,
    output logic [63:0] out_sub3
);

    logic group_valid;
    logic group_taken;
    logic [SAMPLES_PER_PACKET-1:0][1:0][AUDIO_BITS-1:0] group_samples;
    logic acr_request;
    logic acr_taken;
    logic pkt_valid;
    logic pkt_ready;
    header_t pkt_header;
    subpacket_t pkt_sub0;
    subpacket_t pkt_sub1;
    subpacket_t pkt_sub2;
    subpacket_t pkt_sub3;

    audio_sample_buffer i_audio_sample_buffer (
        .clk_pixel     (clk_pixel),
        .reset         (reset),
        .sample_valid  (sample_valid),
        .sample_left   (sample_left),
        .sample_right  (sample_right),
        .sample_ready  (sample_ready),
        .group_valid   (group_valid),
        .group_samples (group_samples),
        .group_taken   (group_taken)
    );

    acr_timer i_acr_timer (
        .clk_pixel   (clk_pixel),
        .reset       (reset),
        .acr_taken   (acr_taken),
        .acr_request (acr_request)
    );

    packet_picker i_packet_picker (
        .clk_pixel       (clk_pixel),
        .reset           (reset),
        .video_field_end (video_field_end),
        .slot_valid      (slot_valid),
        .slot_ready      (slot_ready),
        .acr_request     (acr_request),
        .acr_taken       (acr_taken),
        .group_valid     (group_valid),
        .group_samples   (group_samples),
        .group_taken     (group_taken),
        .pkt_valid       (pkt_valid),
        .pkt_ready       (pkt_ready),
        .pkt_header      (pkt_header),
        .pkt_sub0        (pkt_sub0),
        .pkt_sub1        (pkt_sub1),
        .pkt_sub2        (pkt_sub2),
        .pkt_sub3        (pkt_sub3)
    );

    bch_ecc_stage i_bch_ecc_stage (
        .clk_pixel  (clk_pixel),
        .reset      (reset),
        .pkt_valid  (pkt_valid),
        .pkt_ready  (pkt_ready),
        .pkt_header (pkt_header),
        .pkt_sub0   (pkt_sub0),
        .pkt_sub1   (pkt_sub1),
        .pkt_sub2   (pkt_sub2),
        .pkt_sub3   (pkt_sub3),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_header (out_header),
        .out_sub0   (out_sub0),
        .out_sub1   (out_sub1),
        .out_sub2   (out_sub2),
        .out_sub3   (out_sub3)
    );

endmodule

//--- source/bch_ecc_stage.sv
/* Pipeline register that appends the BCH parity byte to the packet header and
   to each subpacket, with valid/ready on input and output */

`timescale 1ns/1ps

module bch_ecc_stage import hdmi_packet_pkg::*;
(
    input  logic clk_pixel,
    input  logic reset,
    input  logic pkt_valid,
    output logic pkt_ready,
    input  header_t pkt_header,
    input  subpacket_t pkt_sub0,
    input  subpacket_t pkt_sub1,
    input  subpacket_t pkt_sub2,
    input  subpacket_t pkt_sub3,
    output logic out_valid,
    input  logic out_ready,
    output logic [31:0] out_header,
    output logic [63:0] out_sub0,
    output logic [63:0] out_sub1,
    output logic [63:0] out_sub2,
    output logic [63:0] out_sub3
);

    logic load;

    // Serial BCH unrolled over the first nbits of data, bit 0 first
    function automatic logic [7:0] bch_parity(input logic [55:0] data, input int nbits);
        logic [7:0] ecc;
        ecc = 8'h00;
        for (int i = 0; i < 56; i++)
        begin
            if (i < nbits)
                ecc = (ecc >> 1) ^ ((ecc[0] ^ data[i]) ? BCH_POLY : 8'h00);
        end
        return ecc;
    endfunction

    assign pkt_ready = !out_valid || out_ready;
    assign load = pkt_valid && pkt_ready;

    always_ff @(posedge clk_pixel)
    begin
        if (reset)
            out_valid <= 1'b0;
        else if (load)
            out_valid <= 1'b1;
        else if (out_ready)
            out_valid <= 1'b0;
    end

    always_ff @(posedge clk_pixel)
    begin
        if (load)
        begin
            out_header <= {bch_parity({32'h0, pkt_header}, 24), pkt_header};
            out_sub0 <= {bch_parity(pkt_sub0.raw, 56), pkt_sub0.raw};
            out_sub1 <= {bch_parity(pkt_sub1.raw, 56), pkt_sub1.raw};
            out_sub2 <= {bch_parity(pkt_sub2.raw, 56), pkt_sub2.raw};
            out_sub3 <= {bch_parity(pkt_sub3.raw, 56), pkt_sub3.raw};
        end
    end

endmodule

//--- source/packet_picker.sv
/* Chooses the packet for each data island slot by fixed priority, assembles
   header and subpackets and holds them in a valid/ready output register */

`timescale 1ns/1ps

module packet_picker import hdmi_packet_pkg::*;
(
    input  logic clk_pixel,
    input  logic reset,
    input  logic video_field_end,
    input  logic slot_valid,
    output logic slot_ready,
    input  logic acr_request,
    output logic acr_taken,
    input  logic group_valid,
    input  logic [SAMPLES_PER_PACKET-1:0][1:0][AUDIO_BITS-1:0] group_samples,
    output logic group_taken,
    output logic pkt_valid,
    input  logic pkt_ready,
    output header_t pkt_header,
    output subpacket_t pkt_sub0,
    output subpacket_t pkt_sub1,
    output subpacket_t pkt_sub2,
    output subpacket_t pkt_sub3
);

    header_t avi_header;
    header_t spd_header;
    header_t aif_header;
    subpacket_t [3:0] avi_sub;
    subpacket_t [3:0] spd_sub;
    subpacket_t [3:0] aif_sub;

    logic slot_accept;
    logic [7:0] next_type;
    header_t next_header;
    subpacket_t [3:0] next_sub;
    logic [7:0] frame_counter;
    logic aif_sent;
    logic avi_sent;
    logic spd_sent;

    infoframe_builder i_infoframe_builder (
        .clk_pixel  (clk_pixel),
        .avi_header (avi_header),
        .avi_sub    (avi_sub),
        .spd_header (spd_header),
        .spd_sub    (spd_sub),
        .aif_header (aif_header),
        .aif_sub    (aif_sub)
    );

    assign slot_ready = !pkt_valid || pkt_ready;
    assign slot_accept = slot_valid && slot_ready;
    assign acr_taken = slot_accept && next_type == PKT_ACR;
    assign group_taken = slot_accept && next_type == PKT_AUDIO;

    always_comb
    begin
        next_type = PKT_NULL;
        next_header = '0;
        next_sub = '0;
        if (acr_request)
        begin
            next_type = PKT_ACR;
            next_header[7:0] = PKT_ACR;
            for (int k = 0; k < 4; k++)
                next_sub[k].raw = {ACR_N[7:0], ACR_N[15:8], 4'h0, ACR_N[19:16],
                                   ACR_CTS[7:0], ACR_CTS[15:8], 4'h0, ACR_CTS[19:16],
                                   8'h00};
        end
        else if (group_valid)
        begin
            next_type = PKT_AUDIO;
            next_header[7:0] = PKT_AUDIO;
            next_header[15:8] = 8'h0F;
            for (int k = 0; k < SAMPLES_PER_PACKET; k++)
            begin
                // B flag marks the first frame of an IEC block
                next_header[20 + k] = (frame_counter + 8'(k)) == 8'd0;
                next_sub[k].audio.left = group_samples[k][0];
                next_sub[k].audio.right = group_samples[k][1];
                // Valid, user and status stay zero so parity covers the sample only
                next_sub[k].audio.parity_left = ^group_samples[k][0];
                next_sub[k].audio.parity_right = ^group_samples[k][1];
            end
        end
        else if (!aif_sent)
        begin
            next_type = PKT_AUDIO_IF;
            next_header = aif_header;
            next_sub = aif_sub;
        end
        else if (!avi_sent)
        begin
            next_type = PKT_AVI;
            next_header = avi_header;
            next_sub = avi_sub;
        end
        else if (!spd_sent)
        begin
            next_type = PKT_SPD;
            next_header = spd_header;
            next_sub = spd_sub;
        end
    end

    always_ff @(posedge clk_pixel)
    begin
        if (reset)
        begin
            pkt_valid <= 1'b0;
            frame_counter <= 8'd0;
            aif_sent <= 1'b0;
            avi_sent <= 1'b0;
            spd_sent <= 1'b0;
        end
        else
        begin
            if (slot_accept)
                pkt_valid <= 1'b1;
            else if (pkt_ready)
                pkt_valid <= 1'b0;

            if (group_taken)
            begin
                if (frame_counter == 8'(IEC_FRAME_COUNT - SAMPLES_PER_PACKET))
                    frame_counter <= 8'd0;
                else
                    frame_counter <= frame_counter + 8'(SAMPLES_PER_PACKET);
            end

            if (video_field_end)
            begin
                aif_sent <= 1'b0;
                avi_sent <= 1'b0;
                spd_sent <= 1'b0;
            end
            else if (slot_accept)
            begin
                aif_sent <= aif_sent || next_type == PKT_AUDIO_IF;
                avi_sent <= avi_sent || next_type == PKT_AVI;
                spd_sent <= spd_sent || next_type == PKT_SPD;
            end
        end
    end

    always_ff @(posedge clk_pixel)
    begin
        if (slot_accept)
        begin
            pkt_header <= next_header;
            pkt_sub0 <= next_sub[0];
            pkt_sub1 <= next_sub[1];
            pkt_sub2 <= next_sub[2];
            pkt_sub3 <= next_sub[3];
        end
    end

endmodule

//--- source/acr_timer.sv
/* Raises an audio clock regeneration request once every ACR_PERIOD pixel
   cycles and holds it until the picker sends the packet */

`timescale 1ns/1ps

module acr_timer import hdmi_packet_pkg::*;
(
    input  logic clk_pixel,
    input  logic reset,
    input  logic acr_taken,
    output logic acr_request
);

    logic [ACR_COUNT_BITS-1:0] cycle_count;
    logic count_wrap;

    assign count_wrap = cycle_count == ACR_COUNT_BITS'(ACR_PERIOD - 1);

    always_ff @(posedge clk_pixel)
    begin
        if (reset)
        begin
            cycle_count <= '0;
            acr_request <= 1'b0;
        end
        else
        begin
            if (count_wrap)
                cycle_count <= '0;
            else
                cycle_count <= cycle_count + 1'b1;

            // A wrap while still pending folds into the one request
            if (count_wrap)
                acr_request <= 1'b1;
            else if (acr_taken)
                acr_request <= 1'b0;
        end
    end

endmodule

//--- source/audio_sample_buffer.sv
/* Double buffer that gathers four stereo samples per audio packet and offers
   each complete group to the packet picker in arrival order */

`timescale 1ns/1ps

module audio_sample_buffer import hdmi_packet_pkg::*;
(
    input  logic clk_pixel,
    input  logic reset,
    input  logic sample_valid,
    input  logic [AUDIO_BITS-1:0] sample_left,
    input  logic [AUDIO_BITS-1:0] sample_right,
    output logic sample_ready,
    output logic group_valid,
    output logic [SAMPLES_PER_PACKET-1:0][1:0][AUDIO_BITS-1:0] group_samples,
    input  logic group_taken
);

    logic [1:0][SAMPLES_PER_PACKET-1:0][1:0][AUDIO_BITS-1:0] sample_mem;
    logic [1:0] half_full;
    logic fill_half;
    logic send_half;
    logic [1:0] fill_count;
    logic sample_write;

    // Fill and send sides walk the two halves in the same order
    assign sample_ready = !half_full[fill_half];
    assign sample_write = sample_valid && sample_ready;
    assign group_valid = half_full[send_half];
    assign group_samples = sample_mem[send_half];

    always_ff @(posedge clk_pixel)
    begin
        if (sample_write)
        begin
            sample_mem[fill_half][fill_count][0] <= sample_left;
            sample_mem[fill_half][fill_count][1] <= sample_right;
        end
    end

    always_ff @(posedge clk_pixel)
    begin
        if (reset)
        begin
            half_full <= 2'b00;
            fill_half <= 1'b0;
            send_half <= 1'b0;
            fill_count <= 2'd0;
        end
        else
        begin
            if (sample_write)
            begin
                if (fill_count == 2'(SAMPLES_PER_PACKET - 1))
                begin
                    // Group complete, move on even if the next half is still busy
                    fill_count <= 2'd0;
                    half_full[fill_half] <= 1'b1;
                    fill_half <= !fill_half;
                end
                else
                    fill_count <= fill_count + 2'd1;
            end
            if (group_taken && group_valid)
            begin
                half_full[send_half] <= 1'b0;
                send_half <= !send_half;
            end
        end
    end

endmodule

//--- source/infoframe_builder.sv
/* Builds the Audio, AVI and Source Product Description InfoFrames with their
   checksums; bodies are registered on the pixel clock for the picker */

`timescale 1ns/1ps

module infoframe_builder import hdmi_packet_pkg::*;
(
    input  logic clk_pixel,
    output header_t avi_header,
    output subpacket_t [3:0] avi_sub,
    output header_t spd_header,
    output subpacket_t [3:0] spd_sub,
    output header_t aif_header,
    output subpacket_t [3:0] aif_sub
);

    logic [27:0][7:0] avi_pb;
    logic [27:0][7:0] spd_pb;
    logic [27:0][7:0] aif_pb;

    // Fills PB0 so that header plus body sums to zero, then splits into subpackets
    function automatic logic [3:0][55:0] pack_body(input header_t header,
                                                   input logic [27:0][7:0] pb);
        logic [7:0] sum;
        logic [27:0][7:0] body;
        body = pb;
        sum = header[7:0] + header[15:8] + header[23:16];
        for (int i = 1; i < 28; i++)
            sum = sum + body[i];
        body[0] = 8'h00 - sum;
        for (int k = 0; k < 4; k++)
            pack_body[k] = body[7*k +: 7];
    endfunction

    // IEC channel status rate code to the InfoFrame SF field
    function automatic logic [2:0] sf_field(input logic [3:0] iec_code);
        case (iec_code)
            4'b0011: return 3'd1;
            4'b0000: return 3'd2;
            4'b0010: return 3'd3;
            4'b1000: return 3'd4;
            4'b1010: return 3'd5;
            4'b1100: return 3'd6;
            4'b1110: return 3'd7;
            default: return 3'd0;
        endcase
    endfunction

    // Length, version, type
    assign avi_header = {8'd13, 8'd2, PKT_AVI};
    assign spd_header = {8'd25, 8'd1, PKT_SPD};
    assign aif_header = {8'd10, 8'd1, PKT_AUDIO_IF};

    always_comb
    begin
        // RGB, no bar or scan data, 4:3 picture with matching active format
        avi_pb = '0;
        avi_pb[2] = 8'h18;
        avi_pb[4] = {1'b0, VIDEO_ID_CODE};

        spd_pb = '0;
        for (int i = 0; i < 8; i++)
            spd_pb[1 + i] = VENDOR_NAME[63 - 8*i -: 8];
        for (int i = 0; i < 16; i++)
            spd_pb[9 + i] = PRODUCT_DESCRIPTION[127 - 8*i -: 8];
        spd_pb[25] = 8'h00;

        // Two channels, coding from the stream, front left and right only
        aif_pb = '0;
        aif_pb[1] = 8'h01;
        aif_pb[2] = {3'b000, sf_field(SAMPLING_FREQ_CODE), 2'b00};
    end

    always_ff @(posedge clk_pixel)
    begin
        avi_sub <= pack_body(avi_header, avi_pb);
        spd_sub <= pack_body(spd_header, spd_pb);
        aif_sub <= pack_body(aif_header, aif_pb);
    end

endmodule

//--- source/hdmi_packet_pkg.sv
/* Packet type codes, audio, ACR and InfoFrame constants, and the packet word types
   shared by every stage of the data island scheduler */

package hdmi_packet_pkg;

    // Packet type codes as sent in HB0
    localparam logic [7:0] PKT_NULL     = 8'h00;
    localparam logic [7:0] PKT_ACR      = 8'h01;
    localparam logic [7:0] PKT_AUDIO    = 8'h02;
    localparam logic [7:0] PKT_AVI      = 8'h82;
    localparam logic [7:0] PKT_SPD      = 8'h83;
    localparam logic [7:0] PKT_AUDIO_IF = 8'h84;

    // Audio sample format
    localparam int AUDIO_BITS         = 24;
    localparam int SAMPLES_PER_PACKET = 4;
    localparam int IEC_FRAME_COUNT    = 192;

    // Audio clock regeneration, shortened period for simulation
    localparam int ACR_PERIOD     = 2000;
    localparam int ACR_COUNT_BITS = $clog2(ACR_PERIOD);
    localparam logic [19:0] ACR_N   = 20'd6144;
    localparam logic [19:0] ACR_CTS = 20'd25200;

    // InfoFrame payload values
    localparam logic [6:0] VIDEO_ID_CODE      = 7'd1;
    localparam logic [3:0] SAMPLING_FREQ_CODE = 4'b0010;

    // First character sits in the top byte
    localparam logic [8*8-1:0]  VENDOR_NAME         = {"Example", 8'h00};
    localparam logic [8*16-1:0] PRODUCT_DESCRIPTION = "FPGA HDMI Source";

    // x^8+x^7+x^6+1 as a right shifting feedback mask, data taken LSB first
    localparam logic [7:0] BCH_POLY = 8'h83;

    // HB0 in bits 7:0, HB1 in 15:8, HB2 in 23:16
    typedef logic [23:0] header_t;

    // Subpacket bytes SB0 to SB6, SB0 in the low byte
    typedef union packed {
        logic [55:0] raw;
        struct packed {
            logic        parity_right;
            logic        status_right;
            logic        user_right;
            logic        valid_right;
            logic        parity_left;
            logic        status_left;
            logic        user_left;
            logic        valid_left;
            logic [23:0] right;
            logic [23:0] left;
        } audio;
    } subpacket_t;

endpackage
